// File: Makefile
TOP := tbRouterOutput

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f project.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: inputQueue.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module inputQueue (
  input  logic          clk,
  input  logic          rst,
  input  logic          inReq,
  output logic          inAck,
  input  nocPkg::flit_t inFlit,
  input  logic          pop,
  output logic          notEmpty,
  output nocPkg::flit_t head
);
  import nocPkg::*;

  localparam int PTR_W = $clog2(`QUEUE_DEPTH);
  localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);

  flit_t            mem [`QUEUE_DEPTH];
  logic [PTR_W-1:0] rdPtr;
  logic [PTR_W-1:0] wrPtr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             push;

  assign full = (count == CNT_W'(`QUEUE_DEPTH));
  assign push = inReq && !inAck && !full;  // Ack withheld while full.

  //////////////////////////////////////////////////
  // Four-phase receiver
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
      inAck <= 1'b0;
    else if (push)
      inAck <= 1'b1;
    else if (inAck && !inReq)
      inAck <= 1'b0;  // Handshake complete.
  end

  //////////////////////////////////////////////////
  // FIFO
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= inFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= (wrPtr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      if (pop)
        rdPtr <= (rdPtr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign notEmpty = (count != '0);
  assign head     = mem[rdPtr];

endmodule

`default_nettype wire

// File: nocPkg.sv
`default_nettype none

`include "noc_settings.svh"

package nocPkg;

  // Kind 2'b00 is not a valid flit.
  typedef enum logic [1:0] {
    FLIT_HEAD = 2'b01,
    FLIT_BODY = 2'b10,
    FLIT_TAIL = 2'b11
  } flitKind_t;

  typedef struct packed {
    flitKind_t         kind;
    logic [`LEN_W-1:0]  length;  // Total flits in packet, header only.
    logic [`DATA_W-1:0] data;
  } flit_t;

  // Local=0, North=1, East=2, West=3, South=4.
  typedef logic [2:0] portIdx_t;

  // One-hot with bit 0 for idle and bit p+1 for port p.
  typedef logic [`NOC_PORTS:0] grant_t;

  localparam grant_t GRANT_IDLE = grant_t'(1);

endpackage

`default_nettype wire

// File: noc_settings.svh
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

//////////////////////////////////////////////////
// Router output stage sizing
//////////////////////////////////////////////////

`define NOC_PORTS   5   // Local, North, East, West, South.
`define LEN_W       12  // Header length field.
`define DATA_W      16
`define QUEUE_DEPTH 4   // Entries per input queue.

`endif

// File: outputArbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module outputArbiter (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`NOC_PORTS-1:0] notEmpty,
  input  nocPkg::flit_t         headFlit [`NOC_PORTS],
  input  logic                  flitSent,
  output nocPkg::grant_t        grant
);
  import nocPkg::*;

  grant_t                nextGrant;
  logic [`NOC_PORTS-1:0] timerDone;
  logic                  pktOpen;  // A flit went out under the current grant.

  //////////////////////////////////////////////////
  // Packet timers
  //////////////////////////////////////////////////

  generate
    for (genvar p = 0; p < `NOC_PORTS; p++)
    begin : g_timer
      portTimer i_timer (
        .clk      (clk),
        .rst      (rst),
        .active   (grant[p+1]),
        .headFlit (headFlit[p]),
        .flitSent (flitSent),
        .done     (timerDone[p])
      );
    end
  endgenerate

  //////////////////////////////////////////////////
  // Grant state
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant   <= GRANT_IDLE;
      pktOpen <= 1'b0;
    end
    else
    begin
      grant <= nextGrant;
      if (nextGrant != grant)
        pktOpen <= 1'b0;
      else if (flitSent)
        pktOpen <= 1'b1;
    end
  end

  always_comb
  begin : rotate
    portIdx_t curIdx;
    portIdx_t cand;
    logic     holding;
    logic     found;
    int       start;
    int       span;

    curIdx  = '0;
    cand    = '0;
    holding = 1'b0;
    found   = 1'b0;
    for (int p = 0; p < `NOC_PORTS; p++)
    begin
      if (grant[p+1])
      begin
        curIdx  = portIdx_t'(p);
        // An open packet keeps the port even if its queue ran dry.
        holding = !timerDone[p] && (notEmpty[p] || pktOpen);
      end
    end

    // From idle scan from Local; otherwise the other ports after the current one
    start = grant[0] ? 0 : int'(curIdx) + 1;
    span  = grant[0] ? `NOC_PORTS : `NOC_PORTS - 1;

    nextGrant = GRANT_IDLE;
    if (holding)
      nextGrant = grant;
    else
    begin
      for (int k = 0; k < `NOC_PORTS; k++)
      begin
        cand = portIdx_t'((start + k) % `NOC_PORTS);
        if (!found && k < span && notEmpty[cand])
        begin
          nextGrant         = '0;
          nextGrant[cand+1] = 1'b1;
          found             = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: outputLink.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module outputLink (
  input  logic                  clk,
  input  logic                  rst,
  input  nocPkg::grant_t        grant,
  input  logic [`NOC_PORTS-1:0] notEmpty,
  input  nocPkg::flit_t         headFlit [`NOC_PORTS],
  output logic [`NOC_PORTS-1:0] pop,
  output logic                  flitSent,
  output logic                  outReq,
  input  logic                  outAck,
  output nocPkg::flit_t         outFlit
);
  import nocPkg::*;

  typedef enum logic [1:0] {
    LINK_IDLE,
    LINK_REQ,
    LINK_ACK_LOW
  } linkState_t;

  linkState_t state;
  portIdx_t   selIdx;
  portIdx_t   sendIdx;  // Port whose head is on outFlit.
  logic       selValid;

  always_comb
  begin
    selIdx   = '0;
    selValid = 1'b0;
    for (int p = 0; p < `NOC_PORTS; p++)
    begin
      if (grant[p+1])
      begin
        selIdx   = portIdx_t'(p);
        selValid = notEmpty[p];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state  <= LINK_IDLE;
      outReq <= 1'b0;
    end
    else
    begin
      case (state)
        LINK_IDLE:
          if (selValid)
          begin
            outReq <= 1'b1;
            state  <= LINK_REQ;
          end
        LINK_REQ:
          if (outAck)
          begin
            outReq <= 1'b0;
            state  <= LINK_ACK_LOW;
          end
        LINK_ACK_LOW:
          if (!outAck)
            state <= LINK_IDLE;  // Next flit may start.
        default:
          state <= LINK_IDLE;
      endcase
    end
  end

  // Flit is held stable for the whole request phase.
  always_ff @(posedge clk)
  begin
    if (state == LINK_IDLE && selValid)
    begin
      outFlit <= headFlit[selIdx];
      sendIdx <= selIdx;
    end
  end

  assign flitSent = (state == LINK_REQ) && outAck;

  always_comb
  begin
    pop = '0;
    if (flitSent)
      pop[sendIdx] = 1'b1;
  end

endmodule

`default_nettype wire

// File: portTimer.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module portTimer (
  input  logic          clk,
  input  logic          rst,
  input  logic          active,
  input  nocPkg::flit_t headFlit,
  input  logic          flitSent,
  output logic          done
);
  import nocPkg::*;

  logic [`LEN_W-1:0] pktLen;
  logic [`LEN_W-1:0] sentCount;

  always_ff @(posedge clk)
  begin
    if (rst || !active)
    begin
      pktLen    <= '0;
      sentCount <= '0;
    end
    else
    begin
      if (sentCount == '0 && headFlit.kind == FLIT_HEAD)
        pktLen <= headFlit.length;  // Header not yet forwarded.
      if (flitSent)
        sentCount <= sentCount + 1'b1;
    end
  end

  // Counts forwarded flits, not cycles.
  assign done = (sentCount != '0) && (sentCount == pktLen);

endmodule

`default_nettype wire

// File: project.f
+incdir+.
nocPkg.sv
portTimer.sv
outputArbiter.sv
inputQueue.sv
outputLink.sv
routerOutputTop.sv
tbRouterOutput.sv

// File: routerOutputTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module routerOutputTop (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`NOC_PORTS-1:0] inReq,
  output logic [`NOC_PORTS-1:0] inAck,
  input  nocPkg::flit_t         inFlit [`NOC_PORTS],
  output logic                  outReq,
  input  logic                  outAck,
  output nocPkg::flit_t         outFlit
);
  import nocPkg::*;

  logic [`NOC_PORTS-1:0] notEmpty;
  logic [`NOC_PORTS-1:0] pop;
  flit_t                 headFlit [`NOC_PORTS];
  grant_t                grant;
  logic                  flitSent;

  //////////////////////////////////////////////////
  // Input queues, one per port
  //////////////////////////////////////////////////

  generate
    for (genvar p = 0; p < `NOC_PORTS; p++)
    begin : g_queue
      inputQueue i_queue (
        .clk      (clk),
        .rst      (rst),
        .inReq    (inReq[p]),
        .inAck    (inAck[p]),
        .inFlit   (inFlit[p]),
        .pop      (pop[p]),
        .notEmpty (notEmpty[p]),
        .head     (headFlit[p])
      );
    end
  endgenerate

  outputArbiter i_arbiter (
    .clk      (clk),
    .rst      (rst),
    .notEmpty (notEmpty),
    .headFlit (headFlit),
    .flitSent (flitSent),
    .grant    (grant)
  );

  outputLink i_link (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .notEmpty (notEmpty),
    .headFlit (headFlit),
    .pop      (pop),
    .flitSent (flitSent),
    .outReq   (outReq),
    .outAck   (outAck),
    .outFlit  (outFlit)
  );

endmodule

`default_nettype wire

// File: tbRouterOutput.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module tbRouterOutput;
  import nocPkg::*;

  localparam int SAT_PKTS        = 3;   // Packets per port while saturated.
  localparam int RAND_PKTS       = 8;
  localparam int MAX_LEN         = 6;
  localparam int STALL_CYCLES    = 300;
  localparam int SEQ_W           = `DATA_W - 3;
  localparam int MAX_FLITS       = `NOC_PORTS * (SAT_PKTS + RAND_PKTS) * MAX_LEN;
  localparam int WATCHDOG_CYCLES = 200 * MAX_FLITS + STALL_CYCLES;
  localparam int DRAIN_CYCLES    = 200 * `NOC_PORTS * (`QUEUE_DEPTH + 2);  // Queues emptying.

  logic                  clk;
  logic                  rst;
  logic [`NOC_PORTS-1:0] inReq;
  logic [`NOC_PORTS-1:0] inAck;
  flit_t                 inFlit [`NOC_PORTS];
  logic                  outReq;
  logic                  outAck;
  flit_t                 outFlit;

  flit_t expQ [`NOC_PORTS][$];  // Flits still owed per source.
  int    seqNum [`NOC_PORTS];
  int    pushedCnt [`NOC_PORTS];
  bit    burstDone [`NOC_PORTS];
  int    sentTotal = 0;
  int    rxCount   = 0;
  int    pktLeft   = 0;
  int    pktSrc    = 0;
  int    satNext   = 0;
  bit    satPhase  = 1'b0;
  bit    holdAck   = 1'b0;

  routerOutputTop i_dut (
    .clk    (clk),
    .rst    (rst),
    .inReq  (inReq),
    .inAck  (inAck),
    .inFlit (inFlit),
    .outReq (outReq),
    .outAck (outAck),
    .outFlit(outFlit)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #5 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      abortRun($sformatf("FAIL time=%0t %s got=%0h expected=%0h", $time, name, got, exp));
  endtask

  function automatic bit queuesLoaded();
    for (int p = 0; p < `NOC_PORTS; p++)
      if (pushedCnt[p] < `QUEUE_DEPTH && !burstDone[p])
        return 1'b0;
    return 1'b1;
  endfunction

  //////////////////////////////////////////////////
  // Input drivers
  //////////////////////////////////////////////////

  // Starts on a falling edge and returns on the one after ack drops.
  task automatic sendFlit(input int port, input flit_t f);
    expQ[port].push_back(f);
    inFlit[port] = f;
    inReq[port]  = 1'b1;
    @(negedge clk);
    while (!inAck[port])
      @(negedge clk);
    pushedCnt[port]++;
    sentTotal++;
    inReq[port] = 1'b0;
    @(negedge clk);
    while (inAck[port])
      @(negedge clk);
  endtask

  task automatic sendBurst(input int port, input int nPkts, input bit withGaps);
    flit_t f;
    int    len;
    for (int k = 0; k < nPkts; k++)
    begin
      len = $urandom_range(1, MAX_LEN);
      for (int i = 0; i < len; i++)
      begin
        f.kind   = (i == 0) ? FLIT_HEAD : ((i == len - 1) ? FLIT_TAIL : FLIT_BODY);
        f.length = (i == 0) ? `LEN_W'(len) : '0;
        f.data   = {3'(port), SEQ_W'(seqNum[port])};  // Source on top, sequence below.
        seqNum[port]++;
        sendFlit(port, f);
      end
      if (withGaps)
        repeat ($urandom_range(0, 8))
          @(negedge clk);
    end
    burstDone[port] = 1'b1;
  endtask

  //////////////////////////////////////////////////
  // Output receiver and model
  //////////////////////////////////////////////////

  task automatic checkFlit(input flit_t got);
    flit_t exp;
    int    src;
    src = int'(got.data[`DATA_W-1 -: 3]);
    if (src >= `NOC_PORTS)
      abortRun($sformatf("A flit arrived with an unknown source port %0d.", src));
    else if (expQ[src].size() == 0)
      abortRun($sformatf("A flit from port %0d arrived that was never sent.", src));
    else
    begin
      exp = expQ[src].pop_front();
      checkEq("outFlit", 32'(got), 32'(exp));
      if (pktLeft == 0)
      begin
        checkEq("outFlit.kind at packet start", 32'(got.kind), 32'(FLIT_HEAD));
        pktSrc  = src;
        pktLeft = int'(got.length);
        if (satPhase)
        begin
          checkEq("packet source in rotation", 32'(src), 32'(satNext));
          satNext = (satNext + 1) % `NOC_PORTS;
        end
      end
      else
        checkEq("header inside packet", 32'(got.kind == FLIT_HEAD), 32'd0);
      checkEq("packet source", 32'(src), 32'(pktSrc));  // No interleaving.
      pktLeft--;
      rxCount++;
    end
  endtask

  initial
  begin : receiver
    flit_t got;
    outAck = 1'b0;
    forever
    begin
      @(negedge clk);
      if (outReq)
      begin
        while (holdAck)
          @(negedge clk);
        repeat ($urandom_range(0, 3))
          @(negedge clk);
        got    = outFlit;
        outAck = 1'b1;
        @(negedge clk);
        while (outReq)
          @(negedge clk);
        outAck = 1'b0;
        checkFlit(got);
      end
    end
  end

  initial
  begin : watchdog
    repeat (WATCHDOG_CYCLES)
      @(posedge clk);
    abortRun("Timeout: the router stopped delivering flits before all of them arrived.");
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial
  begin : mainSeq
    int stallAt;
    void'($urandom(32'h6bf9c0a3));
    rst   = 1'b1;
    inReq = '0;
    for (int p = 0; p < `NOC_PORTS; p++)
    begin
      inFlit[p]    = '0;
      seqNum[p]    = 0;
      pushedCnt[p] = 0;
      burstDone[p] = 1'b0;
    end
    repeat (5)
      @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    for (int c = 0; c < 10; c++)  // Quiet link after reset.
    begin
      @(negedge clk);
      checkEq("outReq", 32'(outReq), 32'd0);
      checkEq("inAck", 32'(inAck), 32'd0);
    end

    // Saturation phase with acks held until every queue is full.
    satPhase = 1'b1;
    holdAck  = 1'b1;
    fork
      sendBurst(0, SAT_PKTS, 1'b0);
      sendBurst(1, SAT_PKTS, 1'b0);
      sendBurst(2, SAT_PKTS, 1'b0);
      sendBurst(3, SAT_PKTS, 1'b0);
      sendBurst(4, SAT_PKTS, 1'b0);
      begin
        while (!queuesLoaded())
          @(negedge clk);
        holdAck = 1'b0;
      end
    join
    while (rxCount < sentTotal)
      @(negedge clk);
    satPhase = 1'b0;

    // Random traffic with a long output stall.
    stallAt = rxCount + 10;
    fork
      sendBurst(0, RAND_PKTS, 1'b1);
      sendBurst(1, RAND_PKTS, 1'b1);
      sendBurst(2, RAND_PKTS, 1'b1);
      sendBurst(3, RAND_PKTS, 1'b1);
      sendBurst(4, RAND_PKTS, 1'b1);
      begin
        while (rxCount < stallAt)
          @(negedge clk);
        holdAck = 1'b1;
        repeat (STALL_CYCLES)
          @(negedge clk);
        holdAck = 1'b0;
      end
    join
    for (int c = 0; c < DRAIN_CYCLES && rxCount < sentTotal; c++)
      @(negedge clk);
    repeat (20)
      @(negedge clk);

    checkEq("received flit count", 32'(rxCount), 32'(sentTotal));
    checkEq("outReq at end", 32'(outReq), 32'd0);
    checkEq("flits left in open packet", 32'(pktLeft), 32'd0);
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire
